/* Makefile */
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --assert -Wno-fatal --top-module tb_peripheral_subsystem \
		-f files.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/gpio.sv */
/*
 * GPIO: output and output enable, synchronised inputs,
 * rising-edge interrupt status with write-one-to-clear
 */
`timescale 1ns/100ps
`default_nettype none

module gpio
  import periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 we_i,
  input  logic [REG_OFF_W-1:0] addr_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o,
  input  logic [NUM_GPIO-1:0]  gpio_i,
  output logic [NUM_GPIO-1:0]  gpio_o,
  output logic [NUM_GPIO-1:0]  gpio_oe_o,
  output logic [NUM_GPIO-1:0]  intr_o
);

  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] status_clr;
  logic                wr;

  assign wr         = valid_i & we_i;
  assign rise       = sync2_q & ~prev_q;
  assign status_clr = (wr && addr_i == GPIO_INTR_STATUS) ? wdata_i[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~status_clr) | (rise & intr_en_q);
      if (wr) begin
        case (addr_i)
          GPIO_OUT:     out_q     <= wdata_i[NUM_GPIO-1:0];
          GPIO_OE:      oe_q      <= wdata_i[NUM_GPIO-1:0];
          GPIO_INTR_EN: intr_en_q <= wdata_i[NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (addr_i)
      GPIO_IN:          rdata_o[NUM_GPIO-1:0] = sync2_q;
      GPIO_OUT:         rdata_o[NUM_GPIO-1:0] = out_q;
      GPIO_OE:          rdata_o[NUM_GPIO-1:0] = oe_q;
      GPIO_INTR_EN:     rdata_o[NUM_GPIO-1:0] = intr_en_q;
      GPIO_INTR_STATUS: rdata_o[NUM_GPIO-1:0] = status_q;
      default:          rdata_o = 32'h0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = status_q & intr_en_q;

endmodule

`default_nettype wire

/* design/irq_ctrl.sv */
/*
 * Interrupt controller: level gateways, pending and enable bits,
 * claim/complete with lowest-ID selection, software interrupt bit
 */
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl
  import periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 we_i,
  input  logic [REG_OFF_W-1:0] addr_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o,
  input  logic [NUM_SRC-1:0]   src_i,
  output logic                 irq_o,
  output logic                 msip_o
);

  logic [NUM_SRC-1:0]  pending_q;
  logic [NUM_SRC-1:0]  enable_q;
  logic [NUM_SRC-1:0]  inflight_q;
  logic                msip_q;
  logic [NUM_SRC-1:0]  gw_set;
  logic [NUM_SRC-1:0]  cand;
  logic [SRC_ID_W-1:0] claim_id;
  logic                claim_rd;
  logic [NUM_SRC-1:0]  claim_hot;
  logic                complete_we;
  logic [SRC_ID_W-1:0] complete_id;
  logic [NUM_SRC-1:0]  complete_hot;

  // Gateway never fires for source 0 and holds off in-flight sources
  assign gw_set = {src_i[NUM_SRC-1:1], 1'b0} & ~inflight_q;
  assign cand   = pending_q & enable_q;

  always_comb begin
    claim_id = '0;
    // Downward scan so the lowest ID is kept
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (cand[i]) begin
        claim_id = SRC_ID_W'(i);
      end
    end
  end

  assign claim_rd     = valid_i & ~we_i & (addr_i == IRQ_CLAIM);
  assign claim_hot    = (claim_rd && claim_id != '0) ? (NUM_SRC'(1) << claim_id) : '0;
  assign complete_we  = valid_i & we_i & (addr_i == IRQ_CLAIM);
  assign complete_id  = wdata_i[SRC_ID_W-1:0];
  assign complete_hot = complete_we ? (NUM_SRC'(1) << complete_id) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q  <= '0;
      enable_q   <= '0;
      inflight_q <= '0;
      msip_q     <= 1'b0;
    end else begin
      // Claim clear wins over a gateway set in the same cycle
      pending_q  <= (pending_q | gw_set) & ~claim_hot;
      inflight_q <= (inflight_q | claim_hot) & ~complete_hot;
      if (valid_i && we_i) begin
        case (addr_i)
          IRQ_ENABLE: enable_q <= {wdata_i[NUM_SRC-1:1], 1'b0};
          IRQ_MSIP:   msip_q   <= wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (addr_i)
      IRQ_PENDING: rdata_o[NUM_SRC-1:0] = pending_q;
      IRQ_ENABLE:  rdata_o[NUM_SRC-1:0] = enable_q;
      IRQ_CLAIM:   rdata_o[SRC_ID_W-1:0] = claim_id;
      IRQ_MSIP:    rdata_o[0] = msip_q;
      default:     rdata_o = 32'h0;
    endcase
  end

  assign irq_o  = |cand;
  assign msip_o = msip_q;

  // Software may only complete an ID it has claimed before
  a_complete_inflight: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (complete_we && complete_id != '0) |-> inflight_q[complete_id]
  );

endmodule

`default_nettype wire

/* design/mtimer.sv */
/*
 * Machine timer: 32-bit mtime, two compare channels with expiry levels
 */
`timescale 1ns/100ps
`default_nettype none

module mtimer
  import periph_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 we_i,
  input  logic [REG_OFF_W-1:0] addr_i,
  input  logic [31:0]          wdata_i,
  output logic [31:0]          rdata_o,
  output logic [1:0]           intr_o
);

  // ctrl_q[0] runs mtime and ctrl_q[2:1] enable the channels
  logic [2:0]       ctrl_q;
  logic [31:0]      mtime_q;
  logic [1:0][31:0] cmp_q;
  logic [1:0]       intr_q;
  logic             wr;

  assign wr = valid_i & we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q  <= '0;
      mtime_q <= '0;
      cmp_q   <= '1;
      intr_q  <= '0;
    end else begin
      if (wr && addr_i == TMR_MTIME) begin
        mtime_q <= wdata_i;
      end else if (ctrl_q[0]) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr) begin
        case (addr_i)
          TMR_CTRL: ctrl_q   <= wdata_i[2:0];
          TMR_CMP0: cmp_q[0] <= wdata_i;
          TMR_CMP1: cmp_q[1] <= wdata_i;
          default: ;
        endcase
      end
      // Expiry level lags the compare by one cycle
      for (int k = 0; k < 2; k++) begin
        intr_q[k] <= ctrl_q[k+1] && (mtime_q >= cmp_q[k]);
      end
    end
  end

  always_comb begin
    rdata_o = 32'h0;
    case (addr_i)
      TMR_CTRL:  rdata_o[2:0] = ctrl_q;
      TMR_MTIME: rdata_o = mtime_q;
      TMR_CMP0:  rdata_o = cmp_q[0];
      TMR_CMP1:  rdata_o = cmp_q[1];
      default:   rdata_o = 32'h0;
    endcase
  end

  assign intr_o = intr_q;

endmodule

`default_nettype wire

/* design/obi_reg_bridge.sv */
/*
 * OBI slave to register bus bridge, one register access per transfer
 */
`timescale 1ns/100ps
`default_nettype none

module obi_reg_bridge (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        obi_req_i,
  input  logic        obi_we_i,
  input  logic [3:0]  obi_be_i,
  input  logic [31:0] obi_addr_i,
  input  logic [31:0] obi_wdata_i,
  output logic        obi_gnt_o,
  output logic        obi_rvalid_o,
  output logic [31:0] obi_rdata_o,
  output logic        reg_valid_o,
  output logic        reg_we_o,
  output logic [3:0]  reg_be_o,
  output logic [31:0] reg_addr_o,
  output logic [31:0] reg_wdata_o,
  input  logic [31:0] reg_rdata_i
);

  // Sequencer is idle when neither flag is set
  logic        access_q;
  logic        resp_q;
  logic        accept;
  logic        we_q;
  logic [3:0]  be_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  assign obi_gnt_o = ~access_q & ~resp_q;
  assign accept    = obi_req_i & obi_gnt_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      access_q <= 1'b0;
      resp_q   <= 1'b0;
    end else begin
      access_q <= accept;
      resp_q   <= access_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= obi_we_i;
      be_q    <= obi_be_i;
      addr_q  <= obi_addr_i;
      wdata_q <= obi_wdata_i;
    end
    // Writes answer with zero data
    if (access_q) begin
      rdata_q <= we_q ? 32'h0 : reg_rdata_i;
    end
  end

  assign reg_valid_o  = access_q;
  assign reg_we_o     = we_q;
  assign reg_be_o     = be_q;
  assign reg_addr_o   = addr_q;
  assign reg_wdata_o  = wdata_q;
  assign obi_rvalid_o = resp_q;
  assign obi_rdata_o  = rdata_q;

  a_rvalid_after_access: assert property (
    @(posedge clk_i) disable iff (rst_i) obi_rvalid_o |-> $past(reg_valid_o)
  );

endmodule

`default_nettype wire

/* design/periph_pkg.sv */
/*
 * Peripheral subsystem constants: address map, register offsets,
 * interrupt source numbering
 */
`default_nettype none

package periph_pkg;

  // Peripheral select field in the bus address
  localparam int unsigned PERIPH_SEL_LSB = 12;
  localparam int unsigned PERIPH_SEL_W   = 4;

  localparam int unsigned IDX_IRQ    = 0;
  localparam int unsigned IDX_GPIO   = 1;
  localparam int unsigned IDX_TIMER  = 2;
  localparam int unsigned NUM_PERIPH = 3;

  // Word offset inside a peripheral from address bits 5:2
  localparam int unsigned REG_OFF_LSB = 2;
  localparam int unsigned REG_OFF_W   = 4;

  // Interrupt source map where source 0 means no interrupt
  localparam int unsigned NUM_SRC        = 32;
  localparam int unsigned SRC_ID_W       = 5;
  localparam int unsigned SRC_UART_BASE  = 1;
  localparam int unsigned SRC_GPIO_BASE  = 9;
  localparam int unsigned SRC_TIMER_BASE = 17;
  localparam int unsigned NUM_EXT_IRQ    = 8;
  localparam int unsigned SRC_EXT_BASE   = 19;

  localparam int unsigned IRQ_PENDING = 0;
  localparam int unsigned IRQ_ENABLE  = 1;
  localparam int unsigned IRQ_CLAIM   = 2;
  localparam int unsigned IRQ_MSIP    = 3;

  localparam int unsigned NUM_GPIO         = 8;
  localparam int unsigned GPIO_IN          = 0;
  localparam int unsigned GPIO_OUT         = 1;
  localparam int unsigned GPIO_OE          = 2;
  localparam int unsigned GPIO_INTR_EN     = 3;
  localparam int unsigned GPIO_INTR_STATUS = 4;

  localparam int unsigned TMR_CTRL  = 0;
  localparam int unsigned TMR_MTIME = 1;
  localparam int unsigned TMR_CMP0  = 2;
  localparam int unsigned TMR_CMP1  = 3;

endpackage

`default_nettype wire

/* design/peripheral_subsystem.sv */
/*
 * Peripheral subsystem top: OBI bridge, register bus demux,
 * interrupt controller, GPIO, timer and the interrupt source vector
 */
`timescale 1ns/100ps
`default_nettype none

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  logic [3:0]             obi_be_i,
  input  logic [31:0]            obi_addr_i,
  input  logic [31:0]            obi_wdata_i,
  output logic                   obi_gnt_o,
  output logic                   obi_rvalid_o,
  output logic [31:0]            obi_rdata_o,
  input  logic [7:0]             uart_irq_i,
  input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
  input  logic [NUM_GPIO-1:0]    gpio_i,
  output logic [NUM_GPIO-1:0]    gpio_o,
  output logic [NUM_GPIO-1:0]    gpio_oe_o,
  output logic                   irq_o,
  output logic                   msip_o,
  output logic                   timer0_intr_o,
  output logic                   timer1_intr_o
);

  logic                 reg_valid;
  logic                 reg_we;
  logic [3:0]           reg_be;
  logic [31:0]          reg_addr;
  logic [31:0]          reg_wdata;
  logic [31:0]          reg_rdata;
  logic                 bus_valid;
  logic [REG_OFF_W-1:0] reg_off;
  logic                 irq_valid;
  logic                 gpio_valid;
  logic                 tmr_valid;
  logic [31:0]          irq_rdata;
  logic [31:0]          gpio_rdata;
  logic [31:0]          tmr_rdata;
  logic [NUM_GPIO-1:0]  gpio_intr;
  logic [1:0]           tmr_intr;
  logic [NUM_SRC-1:0]   intr_vector;

  // A write with no byte lanes set is dropped
  assign bus_valid = reg_valid & ~(reg_we & ~|reg_be);
  assign reg_off   = reg_addr[REG_OFF_LSB +: REG_OFF_W];

  // ID 0 means no interrupt and the top IDs are unused
  assign intr_vector[0] = 1'b0;
  assign intr_vector[SRC_UART_BASE +: 8] = uart_irq_i;
  assign intr_vector[SRC_GPIO_BASE +: NUM_GPIO] = gpio_intr;
  assign intr_vector[SRC_TIMER_BASE +: 2] = tmr_intr;
  assign intr_vector[SRC_EXT_BASE +: NUM_EXT_IRQ] = ext_irq_i;
  assign intr_vector[NUM_SRC-1:SRC_EXT_BASE+NUM_EXT_IRQ] = '0;

  obi_reg_bridge u_bridge (
    .clk_i,
    .rst_i,
    .obi_req_i,
    .obi_we_i,
    .obi_be_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .reg_valid_o (reg_valid),
    .reg_we_o    (reg_we),
    .reg_be_o    (reg_be),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  reg_bus_demux u_demux (
    .clk_i,
    .rst_i,
    .reg_valid_i  (bus_valid),
    .reg_addr_i   (reg_addr),
    .reg_rdata_o  (reg_rdata),
    .irq_valid_o  (irq_valid),
    .gpio_valid_o (gpio_valid),
    .tmr_valid_o  (tmr_valid),
    .irq_rdata_i  (irq_rdata),
    .gpio_rdata_i (gpio_rdata),
    .tmr_rdata_i  (tmr_rdata)
  );

  irq_ctrl u_irq_ctrl (
    .clk_i,
    .rst_i,
    .valid_i (irq_valid),
    .we_i    (reg_we),
    .addr_i  (reg_off),
    .wdata_i (reg_wdata),
    .rdata_o (irq_rdata),
    .src_i   (intr_vector),
    .irq_o,
    .msip_o
  );

  gpio u_gpio (
    .clk_i,
    .rst_i,
    .valid_i (gpio_valid),
    .we_i    (reg_we),
    .addr_i  (reg_off),
    .wdata_i (reg_wdata),
    .rdata_o (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o  (gpio_intr)
  );

  mtimer u_mtimer (
    .clk_i,
    .rst_i,
    .valid_i (tmr_valid),
    .we_i    (reg_we),
    .addr_i  (reg_off),
    .wdata_i (reg_wdata),
    .rdata_o (tmr_rdata),
    .intr_o  (tmr_intr)
  );

  assign timer0_intr_o = tmr_intr[0];
  assign timer1_intr_o = tmr_intr[1];

endmodule

`default_nettype wire

/* design/reg_bus_demux.sv */
/*
 * Register bus demux: peripheral select decode and read data return
 */
`timescale 1ns/100ps
`default_nettype none

module reg_bus_demux
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        reg_valid_i,
  input  logic [31:0] reg_addr_i,
  output logic [31:0] reg_rdata_o,
  output logic        irq_valid_o,
  output logic        gpio_valid_o,
  output logic        tmr_valid_o,
  input  logic [31:0] irq_rdata_i,
  input  logic [31:0] gpio_rdata_i,
  input  logic [31:0] tmr_rdata_i
);

  logic [PERIPH_SEL_W-1:0] sel;
  logic [NUM_PERIPH-1:0]   valid_vec;

  assign sel = reg_addr_i[PERIPH_SEL_LSB +: PERIPH_SEL_W];

  // Unmapped index gets no strobe and reads zero
  always_comb begin
    valid_vec   = '0;
    reg_rdata_o = 32'h0;
    case (sel)
      IDX_IRQ: begin
        valid_vec[IDX_IRQ] = reg_valid_i;
        reg_rdata_o        = irq_rdata_i;
      end
      IDX_GPIO: begin
        valid_vec[IDX_GPIO] = reg_valid_i;
        reg_rdata_o         = gpio_rdata_i;
      end
      IDX_TIMER: begin
        valid_vec[IDX_TIMER] = reg_valid_i;
        reg_rdata_o          = tmr_rdata_i;
      end
      default: begin
        reg_rdata_o = 32'h0;
      end
    endcase
  end

  assign irq_valid_o  = valid_vec[IDX_IRQ];
  assign gpio_valid_o = valid_vec[IDX_GPIO];
  assign tmr_valid_o  = valid_vec[IDX_TIMER];

  a_one_target: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0({irq_valid_o, gpio_valid_o, tmr_valid_o})
  );

endmodule

`default_nettype wire

/* files.f */
+incdir+tb
design/periph_pkg.sv
design/obi_reg_bridge.sv
design/reg_bus_demux.sv
design/irq_ctrl.sv
design/gpio.sv
design/mtimer.sv
design/peripheral_subsystem.sv
tb/tb_peripheral_subsystem.sv

/* tb/tb_model.svh */
/*
 * Testbench model: xorshift generator, value check, failure stop,
 * reference functions for claim order and register effects
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

task automatic abort_run();
  $display("SIMULATION FAILED");
  $fatal(1);
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) begin
    $display("ERR at %0d ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    abort_run();
  end
endtask

// Lowest pending and enabled ID where source 0 never counts
function automatic logic [31:0] ref_claim(input logic [31:0] pending,
                                          input logic [31:0] enable);
  logic [31:0] id;
  logic        found;
  id    = 32'd0;
  found = 1'b0;
  for (int i = 1; i < NUM_SRC; i++) begin
    if (!found && pending[i] && enable[i]) begin
      id    = i;
      found = 1'b1;
    end
  end
  return id;
endfunction

// Status bits set by rising edges on enabled pins
function automatic logic [31:0] ref_edge_status(input logic [7:0] edges, input logic [7:0] en);
  return {24'h0, edges & en};
endfunction

// Interrupt source positions as seen by the controller
function automatic logic [31:0] ref_src_vector(input logic [7:0] uart, input logic [7:0] gpio,
                                               input logic [1:0] tmr, input logic [7:0] ext);
  logic [31:0] v;
  v = 32'h0;
  v = v | (32'(uart) << SRC_UART_BASE);
  v = v | (32'(gpio) << SRC_GPIO_BASE);
  v = v | (32'(tmr) << SRC_TIMER_BASE);
  v = v | (32'(ext) << SRC_EXT_BASE);
  return v;
endfunction

`endif

/* tb/tb_peripheral_subsystem.sv */
/*
 * Peripheral subsystem testbench: OBI driver, response monitor,
 * directed and random register sequences
 */
`timescale 1ns/100ps
`default_nettype none

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam int unsigned GNT_TIMEOUT    = 20;
  localparam int unsigned RVALID_TIMEOUT = 20;
  localparam int unsigned TIMER_TIMEOUT  = 200;
  localparam int unsigned BUS_ROUNDS     = 8;
  localparam int unsigned EDGE_ROUNDS    = 4;
  localparam int unsigned CLAIM_ROUNDS   = 4;
  localparam int unsigned SETTLE_CYCLES  = 5;
  localparam logic [31:0] TIMER_CMP      = 32'd24;

  logic        clk;
  logic        rst;
  logic        obi_req;
  logic        obi_we;
  logic [3:0]  obi_be;
  logic [31:0] obi_addr;
  logic [31:0] obi_wdata;
  logic        obi_gnt;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;
  logic [7:0]  uart_irq;
  logic [7:0]  ext_irq;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [7:0]  gpio_oe;
  logic        irq;
  logic        msip;
  logic        timer0_intr;
  logic        timer1_intr;

  logic [31:0] rng;
  logic [31:0] model_pend;
  logic        acc_d1;
  logic        acc_d2;
  logic [31:0] exp_data_q[$];
  string       exp_what_q[$];
  logic [31:0] mon_exp;
  string       mon_what;

  `include "tb_model.svh"

  peripheral_subsystem DUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .obi_req_i     (obi_req),
    .obi_we_i      (obi_we),
    .obi_be_i      (obi_be),
    .obi_addr_i    (obi_addr),
    .obi_wdata_i   (obi_wdata),
    .obi_gnt_o     (obi_gnt),
    .obi_rvalid_o  (obi_rvalid),
    .obi_rdata_o   (obi_rdata),
    .uart_irq_i    (uart_irq),
    .ext_irq_i     (ext_irq),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .gpio_oe_o     (gpio_oe),
    .irq_o         (irq),
    .msip_o        (msip),
    .timer0_intr_o (timer0_intr),
    .timer1_intr_o (timer1_intr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] reg_addr(input int unsigned idx, input int unsigned off);
    return (idx << PERIPH_SEL_LSB) | (off << REG_OFF_LSB);
  endfunction

  // Response monitor sees the values from before each edge
  always @(posedge clk) begin
    if (rst) begin
      acc_d1 <= 1'b0;
      acc_d2 <= 1'b0;
    end else begin
      acc_d1 <= obi_req & obi_gnt;
      acc_d2 <= acc_d1;
      check_value(obi_rvalid, acc_d2, "rvalid two cycles after grant");
      if (obi_rvalid && exp_data_q.size() == 0) begin
        $display("A response arrived with no transfer outstanding");
        abort_run();
      end else if (obi_rvalid) begin
        mon_exp  = exp_data_q.pop_front();
        mon_what = exp_what_q.pop_front();
        check_value(obi_rdata, mon_exp, mon_what);
      end
    end
  end

  task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp, input string what);
    logic        got;
    int unsigned n;
    exp_data_q.push_back(exp);
    exp_what_q.push_back(what);
    @(posedge clk);
    obi_req   <= 1'b1;
    obi_we    <= we;
    obi_be    <= 4'hf;
    obi_addr  <= addr;
    obi_wdata <= wdata;
    got = 1'b0;
    for (n = 0; n < GNT_TIMEOUT && !got; n++) begin
      @(posedge clk);
      got = obi_gnt;
    end
    if (!got) begin
      $display("Timeout: the request to address 0x%08h was never granted", addr);
      abort_run();
    end else begin
      obi_req <= 1'b0;
      got = 1'b0;
      for (n = 0; n < RVALID_TIMEOUT && !got; n++) begin
        @(posedge clk);
        got = obi_rvalid;
      end
      if (!got) begin
        $display("Timeout: no response for the transfer to address 0x%08h", addr);
        abort_run();
      end
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_xfer(1'b1, addr, data, 32'h0, "write response data");
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
    bus_xfer(1'b0, addr, 32'h0, exp, what);
  endtask

  task automatic run_bus_test();
    logic [7:0] out_val;
    logic [7:0] oe_val;
    out_val = 8'h0;
    for (int i = 0; i < BUS_ROUNDS; i++) begin
      rng = xorshift32(rng);
      out_val = rng[7:0];
      oe_val  = rng[15:8];
      bus_write(reg_addr(IDX_GPIO, GPIO_OUT), {24'h0, out_val});
      bus_write(reg_addr(IDX_GPIO, GPIO_OE), {24'h0, oe_val});
      bus_read(reg_addr(IDX_GPIO, GPIO_OUT), {24'h0, out_val}, "GPIO_OUT readback");
      bus_read(reg_addr(IDX_GPIO, GPIO_OE), {24'h0, oe_val}, "GPIO_OE readback");
      check_value(gpio_out, out_val, "gpio_o pins");
      check_value(gpio_oe, oe_val, "gpio_oe_o pins");
    end
    // Writes to an unmapped index are dropped and read as zero
    bus_write(reg_addr(7, GPIO_OUT), 32'hffff_ffff);
    bus_read(reg_addr(7, GPIO_OUT), 32'h0, "unmapped read");
    bus_read(reg_addr(IDX_GPIO, GPIO_OUT), {24'h0, out_val}, "GPIO_OUT after unmapped write");
  endtask

  task automatic run_gpio_edges();
    logic [7:0] en;
    logic [7:0] edges;
    for (int i = 0; i < EDGE_ROUNDS; i++) begin
      rng = xorshift32(rng);
      en    = rng[7:0];
      edges = rng[15:8];
      bus_write(reg_addr(IDX_GPIO, GPIO_INTR_EN), {24'h0, en});
      @(posedge clk);
      gpio_in <= edges;
      repeat (SETTLE_CYCLES) @(posedge clk);
      bus_read(reg_addr(IDX_GPIO, GPIO_IN), {24'h0, edges}, "GPIO_IN pins");
      bus_read(reg_addr(IDX_GPIO, GPIO_INTR_STATUS), ref_edge_status(edges, en),
               "GPIO_INTR_STATUS after edges");
      model_pend = model_pend | ref_src_vector(8'h0, edges & en, 2'b00, 8'h0);
      bus_write(reg_addr(IDX_GPIO, GPIO_INTR_STATUS), 32'hff);
      bus_read(reg_addr(IDX_GPIO, GPIO_INTR_STATUS), 32'h0, "GPIO_INTR_STATUS cleared");
      @(posedge clk);
      gpio_in <= 8'h0;
      repeat (SETTLE_CYCLES) @(posedge clk);
    end
    bus_read(reg_addr(IDX_IRQ, IRQ_PENDING), model_pend, "pending after GPIO edges");
    check_value(irq, 1'b0, "irq_o with all enables zero");
  endtask

  task automatic run_claims();
    logic [7:0]  uart;
    logic [7:0]  ext;
    logic [31:0] en;
    logic [31:0] id;
    logic [31:0] claimed[$];
    for (int r = 0; r < CLAIM_ROUNDS; r++) begin
      rng = xorshift32(rng);
      uart = rng[7:0];
      ext  = rng[23:16];
      rng = xorshift32(rng);
      en = rng & 32'hffff_fffe;
      @(posedge clk);
      uart_irq <= uart;
      ext_irq  <= ext;
      bus_write(reg_addr(IDX_IRQ, IRQ_ENABLE), en);
      model_pend = model_pend | ref_src_vector(uart, 8'h0, 2'b00, ext);
      bus_read(reg_addr(IDX_IRQ, IRQ_PENDING), model_pend, "IRQ_PENDING");
      bus_read(reg_addr(IDX_IRQ, IRQ_ENABLE), en, "IRQ_ENABLE readback");
      check_value(irq, |(model_pend & en), "irq_o level");
      do begin
        id = ref_claim(model_pend, en);
        bus_read(reg_addr(IDX_IRQ, IRQ_CLAIM), id, "claimed ID");
        if (id != 32'd0) begin
          model_pend[id[SRC_ID_W-1:0]] = 1'b0;
          claimed.push_back(id);
        end
      end while (id != 32'd0);
      check_value(irq, 1'b0, "irq_o after all claims");
      // Levels drop first so completed sources stay quiet
      @(posedge clk);
      uart_irq <= 8'h0;
      ext_irq  <= 8'h0;
      while (claimed.size() > 0) begin
        bus_write(reg_addr(IDX_IRQ, IRQ_CLAIM), claimed.pop_front());
      end
      bus_read(reg_addr(IDX_IRQ, IRQ_CLAIM), 32'h0, "claim after completion");
    end
  endtask

  task automatic run_timer();
    logic        got;
    int unsigned n;
    check_value(timer0_intr, 1'b0, "timer0 before start");
    bus_read(reg_addr(IDX_TIMER, TMR_CMP1), 32'hffff_ffff, "CMP1 reset value");
    bus_write(reg_addr(IDX_TIMER, TMR_CMP0), TIMER_CMP);
    bus_read(reg_addr(IDX_TIMER, TMR_CMP0), TIMER_CMP, "CMP0 readback");
    bus_write(reg_addr(IDX_TIMER, TMR_MTIME), 32'h0);
    bus_write(reg_addr(IDX_IRQ, IRQ_ENABLE), 32'h1 << SRC_TIMER_BASE);
    bus_write(reg_addr(IDX_TIMER, TMR_CTRL), 32'h3);
    got = 1'b0;
    for (n = 0; n < TIMER_TIMEOUT && !got; n++) begin
      @(posedge clk);
      got = timer0_intr;
    end
    if (!got) begin
      $display("Timeout: timer channel 0 never expired");
      abort_run();
    end else begin
      check_value(timer1_intr, 1'b0, "timer1 while channel 0 fires");
      bus_read(reg_addr(IDX_IRQ, IRQ_CLAIM), SRC_TIMER_BASE, "timer claim ID");
      bus_write(reg_addr(IDX_TIMER, TMR_CTRL), 32'h0);
      bus_write(reg_addr(IDX_IRQ, IRQ_CLAIM), SRC_TIMER_BASE);
      check_value(timer0_intr, 1'b0, "timer0 after disable");
      check_value(timer1_intr, 1'b0, "timer1 never enabled");
      check_value(irq, 1'b0, "irq_o after timer completion");
    end
  endtask

  task automatic run_msip();
    bus_write(reg_addr(IDX_IRQ, IRQ_MSIP), 32'h1);
    check_value(msip, 1'b1, "msip_o set");
    bus_read(reg_addr(IDX_IRQ, IRQ_MSIP), 32'h1, "IRQ_MSIP readback");
    bus_write(reg_addr(IDX_IRQ, IRQ_MSIP), 32'h0);
    check_value(msip, 1'b0, "msip_o cleared");
  endtask

  initial begin
    rst        = 1'b1;
    obi_req    = 1'b0;
    obi_we     = 1'b0;
    obi_be     = 4'h0;
    obi_addr   = 32'h0;
    obi_wdata  = 32'h0;
    uart_irq   = 8'h0;
    ext_irq    = 8'h0;
    gpio_in    = 8'h0;
    rng        = 32'h375d;
    model_pend = 32'h0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_value(obi_gnt, 1'b1, "gnt idle after reset");
    check_value(obi_rvalid, 1'b0, "rvalid after reset");
    check_value({irq, msip, timer0_intr, timer1_intr}, 4'h0, "interrupt outputs after reset");
    check_value({gpio_out, gpio_oe}, 16'h0, "GPIO outputs after reset");
    run_bus_test();
    run_gpio_edges();
    run_claims();
    run_timer();
    run_msip();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
